// File: hwcnn_inst_pkg.sv
`default_nettype none

package hwcnn_inst_pkg;

	localparam int LINE_LEN_W = 9;

	// Last read to last result beat (BRAM 1, PE 3, write-back 2)
	localparam int DRAIN_CYCLES = 6;

	typedef enum logic [1:0] {
		OP_NOP       = 2'd0,
		OP_CONV      = 2'd1,
		OP_CONV_POOL = 2'd2
	} opcode_t;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_READ,
		ST_DRAIN,
		ST_DONE
	} ctrl_state_t;

endpackage

`default_nettype wire

// File: hwcnn_data_pkg.sv
`default_nettype none

package hwcnn_data_pkg;

	localparam int KER_TAPS = 3;   // Taps per 1-D kernel
	localparam int TILE_LEN = 4;   // Samples per F(2,3) tile

	// Kernel taps plus one bias slot
	localparam int TAP_SEL_W = $clog2(KER_TAPS + 1);

	typedef logic signed [7:0]  feature_t;
	typedef logic signed [7:0]  weight_t;
	typedef logic signed [9:0]  wino_t;   // Doubled G*g
	typedef logic signed [23:0] acc_t;

endpackage

`default_nettype wire

// File: buffer_pool.sv
`timescale 1ns/1ps
`default_nettype none

module buffer_pool import hwcnn_data_pkg::*; #(
	parameter int ADDR_LEN_BP = 8
) (
	input  logic                   clk,
	input  logic                   feat_we,
	input  logic [ADDR_LEN_BP-1:0] feat_addr,
	input  feature_t               feat_data,
	input  logic                   rd_en,
	input  logic [ADDR_LEN_BP-1:0] rd_addr,
	output logic                   samp_valid,
	output feature_t               samp
);

	feature_t mem [2**ADDR_LEN_BP];   // One feature line

	always_ff @(posedge clk) begin
		if (feat_we)
			mem[feat_addr] <= feat_data;
	end

	// Registered read port
	always_ff @(posedge clk) begin
		samp_valid <= rd_en;
		if (rd_en)
			samp <= mem[rd_addr];
	end

endmodule

`default_nettype wire

// File: weight_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module weight_buffer import hwcnn_data_pkg::*; #(
	parameter int X_PE = 4
) (
	input  logic                           clk,
	input  logic                           rst,
	input  logic                           ker_we,
	input  logic [$clog2(X_PE)-1:0]        ker_pe,
	input  logic [TAP_SEL_W-1:0]           ker_tap,
	input  weight_t                        ker_data,
	output wino_t [X_PE-1:0][TILE_LEN-1:0] ker_wino,
	output acc_t [X_PE-1:0]                bias
);

	weight_t taps [X_PE][KER_TAPS];   // Raw g0..g2 per PE

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int p = 0; p < X_PE; p++) begin
				bias[p] <= '0;
				for (int k = 0; k < KER_TAPS; k++)
					taps[p][k] <= '0;
			end
		end else if (ker_we) begin
			if (ker_tap == TAP_SEL_W'(KER_TAPS))
				bias[ker_pe] <= acc_t'(ker_data);   // Sign-extended
			else
				taps[ker_pe][ker_tap] <= ker_data;
		end
	end

	// G*g scaled by two so every term stays integer
	always_comb begin
		wino_t g0;
		wino_t g1;
		wino_t g2;
		for (int p = 0; p < X_PE; p++) begin
			g0 = wino_t'(taps[p][0]);
			g1 = wino_t'(taps[p][1]);
			g2 = wino_t'(taps[p][2]);
			ker_wino[p][0] = g0 + g0;
			ker_wino[p][1] = g0 + g1 + g2;
			ker_wino[p][2] = g0 - g1 + g2;
			ker_wino[p][3] = g2 + g2;
		end
	end

endmodule

`default_nettype wire

// File: window_shift_register.sv
`timescale 1ns/1ps
`default_nettype none

module window_shift_register import hwcnn_data_pkg::*; (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    line_start,
	input  logic                    samp_valid,
	input  feature_t                samp,
	output logic                    tile_valid,
	output feature_t [TILE_LEN-1:0] tile
);

	feature_t [TILE_LEN-2:0]     hist;   // Top entry is newest
	logic [$clog2(TILE_LEN)-1:0] phase;

	always_ff @(posedge clk) begin
		if (rst) begin
			phase <= '0;
			tile_valid <= 1'b0;
		end else begin
			tile_valid <= 1'b0;
			if (line_start) begin
				phase <= '0;
			end else if (samp_valid) begin
				// Fourth sample opens a tile, then step by two
				tile_valid <= phase == 2'(TILE_LEN - 1);
				phase <= (phase == 2'(TILE_LEN - 1)) ? 2'(TILE_LEN - 2) : phase + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (samp_valid) begin
			hist <= {samp, hist[TILE_LEN-2:1]};
			tile <= {samp, hist};   // tile[0] is d0
		end
	end

endmodule

`default_nettype wire

// File: wino_pe_core.sv
`timescale 1ns/1ps
`default_nettype none

module wino_pe_core import hwcnn_data_pkg::*; #(
	parameter int X_PE = 4
) (
	input  logic                           clk,
	input  logic                           rst,
	input  logic                           tile_valid,
	input  feature_t [TILE_LEN-1:0]        tile,
	input  wino_t [X_PE-1:0][TILE_LEN-1:0] ker_wino,
	input  acc_t [X_PE-1:0]                bias,
	output logic                           pair_valid,
	output acc_t [X_PE-1:0][1:0]           pair
);

	typedef logic signed [8:0] dt_t;

	dt_t [TILE_LEN-1:0]            dt;   // B^T d, shared by all PEs
	acc_t [X_PE-1:0][TILE_LEN-1:0] prod;
	acc_t [X_PE-1:0]               sum0;
	acc_t [X_PE-1:0]               sum1;
	logic                          dt_valid;
	logic                          prod_valid;

	always_ff @(posedge clk) begin
		if (rst) begin
			dt_valid <= 1'b0;
			prod_valid <= 1'b0;
			pair_valid <= 1'b0;
		end else begin
			dt_valid <= tile_valid;
			prod_valid <= dt_valid;
			pair_valid <= prod_valid;
		end
	end

	////////////////////////////////////////
	// Stage 1 input transform
	always_ff @(posedge clk) begin
		if (tile_valid) begin
			dt[0] <= dt_t'(tile[0]) - dt_t'(tile[2]);
			dt[1] <= dt_t'(tile[1]) + dt_t'(tile[2]);
			dt[2] <= dt_t'(tile[2]) - dt_t'(tile[1]);
			dt[3] <= dt_t'(tile[1]) - dt_t'(tile[3]);
		end
	end

	// A^T m, still at twice the real scale
	always_comb begin
		for (int p = 0; p < X_PE; p++) begin
			sum0[p] = prod[p][0] + prod[p][1] + prod[p][2];
			sum1[p] = prod[p][1] - prod[p][2] - prod[p][3];
		end
	end

	////////////////////////////////////////
	// Stage 2 multiplies, stage 3 halve and bias
	always_ff @(posedge clk) begin
		for (int p = 0; p < X_PE; p++) begin
			if (dt_valid) begin
				for (int k = 0; k < TILE_LEN; k++)
					prod[p][k] <= acc_t'(dt[k]) * acc_t'(ker_wino[p][k]);
			end
			if (prod_valid) begin
				pair[p][0] <= (sum0[p] >>> 1) + bias[p];   // Exact, sum is even
				pair[p][1] <= (sum1[p] >>> 1) + bias[p];
			end
		end
	end

endmodule

`default_nettype wire

// File: write_back.sv
`timescale 1ns/1ps
`default_nettype none

module write_back import hwcnn_data_pkg::*; #(
	parameter int X_PE         = 4,
	parameter int ADDR_LEN_RES = 8
) (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    line_start,
	input  logic                    pool,
	input  logic [ADDR_LEN_RES-1:0] res_base,
	input  logic                    pair_valid,
	input  acc_t [X_PE-1:0][1:0]    pair,
	output logic                    res_valid,
	output logic [ADDR_LEN_RES-1:0] res_addr,
	output acc_t [X_PE-1:0]         res_data
);

	acc_t [X_PE-1:0]         second;   // Odd outputs waiting a cycle
	logic                    second_pend;
	logic [ADDR_LEN_RES-1:0] next_addr;
	logic                    beat;

	assign beat = pair_valid || second_pend;

	always_ff @(posedge clk) begin
		if (rst) begin
			res_valid <= 1'b0;
			second_pend <= 1'b0;
		end else begin
			res_valid <= beat;
			second_pend <= pair_valid && !pool;
		end
	end

	always_ff @(posedge clk) begin
		if (line_start)
			next_addr <= res_base;
		else if (beat)
			next_addr <= next_addr + 1'b1;
		if (beat)
			res_addr <= next_addr;
		for (int p = 0; p < X_PE; p++) begin
			if (pair_valid) begin
				// Pool by two keeps the larger output
				res_data[p] <= (pool && pair[p][1] > pair[p][0]) ? pair[p][1] : pair[p][0];
				second[p] <= pair[p][1];
			end else if (second_pend) begin
				res_data[p] <= second[p];
			end
		end
	end

endmodule

`default_nettype wire

// File: top_control.sv
`timescale 1ns/1ps
`default_nettype none

module top_control import hwcnn_inst_pkg::*; #(
	parameter int ADDR_LEN_BP  = 8,
	parameter int ADDR_LEN_RES = 8
) (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    inst_valid,
	input  opcode_t                 inst_op,
	input  logic [ADDR_LEN_BP-1:0]  inst_feat_addr,
	input  logic [LINE_LEN_W-1:0]   inst_line_len,
	input  logic [ADDR_LEN_RES-1:0] inst_res_addr,
	output logic                    busy,
	output logic                    done,
	output logic                    rd_en,
	output logic [ADDR_LEN_BP-1:0]  rd_addr,
	output logic                    line_start,
	output logic                    pool,
	output logic [ADDR_LEN_RES-1:0] res_base
);

	ctrl_state_t           state;
	logic [LINE_LEN_W-1:0] cnt;   // Reads left, then drain cycles left
	logic                  accept;
	logic                  is_conv;

	assign accept  = inst_valid && state == ST_IDLE;
	assign is_conv = inst_op inside {OP_CONV, OP_CONV_POOL};
	assign busy    = state != ST_IDLE;
	assign done    = state == ST_DONE;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= ST_IDLE;
			rd_en <= 1'b0;
			line_start <= 1'b0;
			cnt <= '0;
		end else begin
			line_start <= accept && is_conv;   // With first read
			case (state)
				ST_IDLE: begin
					if (accept) begin
						state <= is_conv ? ST_READ : ST_DONE;
						rd_en <= is_conv;
						cnt <= inst_line_len;
					end
				end
				ST_READ: begin
					cnt <= cnt - 1'b1;
					if (cnt == LINE_LEN_W'(1)) begin
						state <= ST_DRAIN;
						rd_en <= 1'b0;
						cnt <= LINE_LEN_W'(DRAIN_CYCLES - int'(pool));   // Pooled line ends a beat early
					end
				end
				ST_DRAIN: begin
					cnt <= cnt - 1'b1;
					if (cnt == '0)
						state <= ST_DONE;
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			rd_addr <= inst_feat_addr;
			pool <= inst_op == OP_CONV_POOL;
			res_base <= inst_res_addr;
		end else if (rd_en) begin
			rd_addr <= rd_addr + 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: hwcnn_top.sv
`timescale 1ns/1ps
`default_nettype none

module hwcnn_top import hwcnn_inst_pkg::*, hwcnn_data_pkg::*; #(
	parameter int X_PE         = 4,
	parameter int ADDR_LEN_BP  = 8,
	parameter int ADDR_LEN_RES = 8
) (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    inst_valid,
	input  opcode_t                 inst_op,
	input  logic [ADDR_LEN_BP-1:0]  inst_feat_addr,
	input  logic [LINE_LEN_W-1:0]   inst_line_len,
	input  logic [ADDR_LEN_RES-1:0] inst_res_addr,
	output logic                    busy,
	output logic                    done,
	input  logic                    feat_we,
	input  logic [ADDR_LEN_BP-1:0]  feat_addr,
	input  feature_t                feat_data,
	input  logic                    ker_we,
	input  logic [$clog2(X_PE)-1:0] ker_pe,
	input  logic [TAP_SEL_W-1:0]    ker_tap,
	input  weight_t                 ker_data,
	output logic                    res_valid,
	output logic [ADDR_LEN_RES-1:0] res_addr,
	output acc_t [X_PE-1:0]         res_data
);

	logic                           rd_en;
	logic [ADDR_LEN_BP-1:0]         rd_addr;
	logic                           line_start;
	logic                           pool;
	logic [ADDR_LEN_RES-1:0]        res_base;
	logic                           samp_valid;
	feature_t                       samp;
	logic                           tile_valid;
	feature_t [TILE_LEN-1:0]        tile;
	wino_t [X_PE-1:0][TILE_LEN-1:0] ker_wino;
	acc_t [X_PE-1:0]                bias;
	logic                           pair_valid;
	acc_t [X_PE-1:0][1:0]           pair;

	////////////////////////////////////////
	// Control and feature path
	top_control #(.ADDR_LEN_BP(ADDR_LEN_BP), .ADDR_LEN_RES(ADDR_LEN_RES)) u_ctrl (.*);
	buffer_pool #(.ADDR_LEN_BP(ADDR_LEN_BP)) u_bp (.*);
	window_shift_register u_wsr (.*);

	////////////////////////////////////////
	// Compute and result path
	weight_buffer #(.X_PE(X_PE)) u_wb (.*);
	wino_pe_core #(.X_PE(X_PE)) u_pec (.*);
	write_back #(.X_PE(X_PE), .ADDR_LEN_RES(ADDR_LEN_RES)) u_wbk (.*);

endmodule

`default_nettype wire

// File: hwcnn_assert.sv
`timescale 1ns/1ps
`default_nettype none

module hwcnn_assert (
	input logic clk,
	input logic rst,
	input logic busy,
	input logic done,
	input logic res_valid
);

	int unsigned fails = 0;   // Failed assertion count

	////////////////////////////////////////
	// Control timing
	reset_idle: assert property (@(posedge clk) rst |=> !busy && !res_valid)
		else begin
			$error("busy or res_valid high after reset");
			fails++;
		end

	done_pulse: assert property (@(posedge clk) disable iff (rst) done |=> !done && !busy)
		else begin
			$error("done longer than one cycle or busy held after done");
			fails++;
		end

	busy_end: assert property (@(posedge clk) disable iff (rst) $fell(busy) |-> $past(done))
		else begin
			$error("busy fell without done");
			fails++;
		end

	res_in_busy: assert property (@(posedge clk) disable iff (rst) res_valid |-> busy)
		else begin
			$error("res_valid while idle");
			fails++;
		end

endmodule

bind hwcnn_top hwcnn_assert u_assert (.clk, .rst, .busy, .done, .res_valid);

`default_nettype wire

// File: hwcnn_tb.sv
`timescale 1ns/1ps
`default_nettype none

module hwcnn_tb import hwcnn_inst_pkg::*, hwcnn_data_pkg::*; ();

	localparam int X_PE  = 4;
	localparam int MAX_L = 16;

	logic                  clk = 1'b0;
	logic                  rst;
	logic                  inst_valid;
	opcode_t               inst_op;
	logic [7:0]            inst_feat_addr;
	logic [LINE_LEN_W-1:0] inst_line_len;
	logic [7:0]            inst_res_addr;
	logic                  busy;
	logic                  done;
	logic                  feat_we;
	logic [7:0]            feat_addr;
	feature_t              feat_data;
	logic                  ker_we;
	logic [1:0]            ker_pe;
	logic [TAP_SEL_W-1:0]  ker_tap;
	weight_t               ker_data;
	logic                  res_valid;
	logic [7:0]            res_addr;
	acc_t [X_PE-1:0]       res_data;

	integer   seed;
	feature_t x [MAX_L];
	weight_t  g [X_PE][KER_TAPS];
	weight_t  b [X_PE];
	acc_t     exp_data [256][X_PE];   // Indexed by result address
	logic     exp_valid [256];
	int       beats;
	int       errors;
	int       tests;

	hwcnn_top #(.X_PE(X_PE), .ADDR_LEN_BP(8), .ADDR_LEN_RES(8)) DUT (.*);

	always #5 clk = ~clk;

	// y[n] = g0*x[n] + g1*x[n+1] + g2*x[n+2] + bias
	function automatic acc_t ref_out(input int pe, input int n);
		acc_t y;
		y = acc_t'(b[pe]);
		for (int k = 0; k < KER_TAPS; k++)
			y += acc_t'(g[pe][k]) * acc_t'(x[n + k]);
		return y;
	endfunction

	////////////////////////////////////////
	// Comparing process
	always @(negedge clk) begin
		if (res_valid) begin
			beats++;
			if (!exp_valid[res_addr]) begin
				$display("error at %0t: unexpected result at address %0d", $time, res_addr);
				errors++;
			end else begin
				for (int p = 0; p < X_PE; p++) begin
					if (res_data[p] !== exp_data[res_addr][p]) begin
						$display("error at %0t: addr %0d lane %0d got %0d, expected %0d",
							$time, res_addr, p, res_data[p], exp_data[res_addr][p]);
						errors++;
					end
				end
				exp_valid[res_addr] = 1'b0;   // Catch repeated addresses
			end
		end
	end

	task automatic load_data();
		for (int n = 0; n < MAX_L; n++) begin
			@(negedge clk);
			feat_we = 1'b1;
			feat_addr = 8'(n);
			feat_data = x[n];
		end
		@(negedge clk);
		feat_we = 1'b0;
		for (int p = 0; p < X_PE; p++) begin
			for (int t = 0; t <= KER_TAPS; t++) begin
				@(negedge clk);
				ker_we = 1'b1;
				ker_pe = 2'(p);
				ker_tap = TAP_SEL_W'(t);
				ker_data = (t == KER_TAPS) ? b[p] : g[p][t];   // Tap 3 is the bias
			end
		end
		@(negedge clk);
		ker_we = 1'b0;
	endtask

	task automatic run_line(input string name, input opcode_t op, input int len,
			input int base, input bit inject);
		int   nexp;
		int   cycles;
		int   err0;
		acc_t y0;
		acc_t y1;
		err0 = errors;
		nexp = 0;
		for (int a = 0; a < 256; a++)
			exp_valid[a] = 1'b0;
		for (int n = 0; n < len - 2 && op != OP_NOP; n++) begin
			if (op == OP_CONV || n % 2 == 0) begin
				for (int p = 0; p < X_PE; p++) begin
					y0 = ref_out(p, n);
					y1 = ref_out(p, n + 1);
					exp_data[base + nexp][p] = (op == OP_CONV_POOL && y1 > y0) ? y1 : y0;
				end
				exp_valid[base + nexp] = 1'b1;
				nexp++;
			end
		end
		beats = 0;
		@(negedge clk);
		inst_valid = 1'b1;
		inst_op = op;
		inst_feat_addr = 8'd0;
		inst_line_len = LINE_LEN_W'(len);
		inst_res_addr = 8'(base);
		@(negedge clk);
		inst_valid = 1'b0;
		if (inject) begin   // Second instruction while busy
			@(negedge clk);
			inst_valid = 1'b1;
			inst_res_addr = 8'(base + 100);
			@(negedge clk);
			inst_valid = 1'b0;
		end
		cycles = 0;
		while (!done && cycles < 200) begin
			@(negedge clk);
			cycles++;
		end
		if (!done) begin
			$display("done did not arrive within 200 cycles in test %s", name);
			errors++;
		end
		if (beats != nexp) begin
			$display("error at %0t: %s gave %0d beats, expected %0d", $time, name, beats, nexp);
			errors++;
		end
		tests++;
		$display("test %s: %0d errors", name, errors - err0);
	endtask

	task automatic check_idle();
		int err0;
		err0 = errors;
		repeat (10) begin
			@(negedge clk);
			if (busy || done || res_valid) begin
				$display("error at %0t: activity with no instruction", $time);
				errors++;
			end
		end
		tests++;
		$display("test idle: %0d errors", errors - err0);
	endtask

	initial begin
		seed = 32'he4b31cbc;
		errors = 0;
		tests = 0;
		beats = 0;
		rst = 1'b1;
		inst_valid = 1'b0;
		inst_op = OP_NOP;
		inst_feat_addr = '0;
		inst_line_len = '0;
		inst_res_addr = '0;
		feat_we = 1'b0;
		feat_addr = '0;
		feat_data = '0;
		ker_we = 1'b0;
		ker_pe = '0;
		ker_tap = '0;
		ker_data = '0;
		for (int a = 0; a < 256; a++)
			exp_valid[a] = 1'b0;
		repeat (3) @(negedge clk);
		rst = 1'b0;

		check_idle();

		// Identity kernel gives the shifted line
		for (int n = 0; n < MAX_L; n++)
			x[n] = feature_t'(n * 7 - 50);
		for (int p = 0; p < X_PE; p++) begin
			g[p][0] = 8'sd0;
			g[p][1] = 8'sd1;
			g[p][2] = 8'sd0;
			b[p] = 8'sd0;
		end
		load_data();
		run_line("identity", OP_CONV, 8, 0, 1'b0);

		for (int n = 0; n < MAX_L; n++)
			x[n] = feature_t'($random(seed));
		for (int p = 0; p < X_PE; p++) begin
			for (int k = 0; k < KER_TAPS; k++)
				g[p][k] = weight_t'($random(seed));
			b[p] = weight_t'($random(seed));
		end
		load_data();
		run_line("random", OP_CONV, 16, 10, 1'b0);
		run_line("pool", OP_CONV_POOL, 16, 40, 1'b0);
		run_line("ignored", OP_CONV, 16, 60, 1'b1);
		run_line("nop", OP_NOP, 16, 0, 1'b0);

		repeat (2) @(negedge clk);
		$display("%0d tests, %0d errors, %0d assertion failures", tests, errors,
			DUT.u_assert.fails);
		if (errors == 0 && DUT.u_assert.fails == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: hwcnn.f
hwcnn_inst_pkg.sv
hwcnn_data_pkg.sv
buffer_pool.sv
weight_buffer.sv
window_shift_register.sv
wino_pe_core.sv
write_back.sv
top_control.sv
hwcnn_top.sv
hwcnn_assert.sv
hwcnn_tb.sv

// File: Bender.yml
package:
  name: hwcnn

sources:
  - hwcnn_inst_pkg.sv
  - hwcnn_data_pkg.sv
  - buffer_pool.sv
  - weight_buffer.sv
  - window_shift_register.sv
  - wino_pe_core.sv
  - write_back.sv
  - top_control.sv
  - hwcnn_top.sv
  - target: test
    files:
      - hwcnn_assert.sv
      - hwcnn_tb.sv
